// File: bench/me_search_checker.sv
module me_search_checker
    import me_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        sram_ready,
    input best_match_t best,
    input logic        best_valid
);

    timeunit 1ns;
    timeprecision 100ps;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result pulse
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_single_pulse : assert property (
        @(posedge clk) disable iff (rst)
        best_valid |=> !best_valid
    ) else $error("best_valid stayed high for two cycles");

    // a result needs a strip column two edges earlier.
    a_needs_ready : assert property (
        @(posedge clk) disable iff (rst)
        (!$past(sram_ready, 1) && !$past(sram_ready, 2) && !$past(sram_ready, 3))
            |-> !best_valid
    ) else $error("best_valid rose while sram_ready had been low");

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reset values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_reset_low : assert property (
        @(posedge clk)
        rst |-> (!sram_ready && !best_valid && best == '0)
    ) else $error("outputs not low during reset");

endmodule

bind me_search_top me_search_checker u_checker (
    .clk        (clk),
    .rst        (rst),
    .sram_ready (sram_ready),
    .best       (best),
    .best_valid (best_valid)
);

// File: bench/me_search_tb.sv
`include "me_config.svh"

module me_search_tb
    import me_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 4;
    localparam int RAND_CYCLES = 1200; // random data, random next_line.
    localparam int TIE_CYCLES  = 400;  // constant reference, copied columns.
    localparam int EXT_CYCLES  = 300;  // zero reference against full-scale block.
    localparam int RUN_CYCLES  = RAND_CYCLES + TIE_CYCLES + EXT_CYCLES;
    localparam int LAST_ADDR   = `ME_LINE_WORDS - 1;
    localparam int COL_PIX     = `ME_STRIP_PIX - `ME_OFFSETS + 1;
    localparam int MAX_SAD     = `ME_BLOCK_COLS * COL_PIX * 255;
    localparam logic [`ME_BANKS-1:0] FIRST_BANK = `ME_BANKS'(1);

    logic        clk       = 1'b0;
    logic        rst       = 1'b1;
    logic        next_line = 1'b0;
    ref_word_u   ref_in    = '0;
    ref_word_u   cur_col   = '0;
    logic        sram_ready;
    best_match_t best;
    logic        best_valid;

    integer      seed = 32'h98af;
    int          cyc = 0;
    int          err_cnt = 0;
    int          chk_cnt = 0;
    int          dut_res = 0;
    int          mdl_res = 0;
    int          tie_res = 0;
    int          ext_res = 0;
    int          ready_rises = 0;
    int          tie_a = 0;
    int          tie_b = 0;
    logic [63:0] tie_word = '0;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [63:0]          m_mem [`ME_BANKS][`ME_LINE_WORDS];
    ref_word_u            m_q [`ME_BANKS];
    int                   m_addr = 0;
    logic [`ME_BANKS-1:0] m_wsel = '0;
    logic [`ME_BANKS-1:0] m_rsel = '0;
    logic                 m_ready = 1'b0;
    pixel_t               m_strip [`ME_STRIP_PIX];
    int                   m_acc [`ME_OFFSETS];
    int                   m_vec [`ME_OFFSETS];
    int                   m_cnt = 0;
    logic                 m_vec_valid = 1'b0;
    logic                 m_best_valid = 1'b0;
    int                   m_best_sad = 0;
    int                   m_best_off = 0;

    me_search_top u_dut (
        .clk        (clk),
        .rst        (rst),
        .next_line  (next_line),
        .ref_in     (ref_in),
        .cur_col    (cur_col),
        .sram_ready (sram_ready),
        .best       (best),
        .best_valid (best_valid)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int pix_dist(input pixel_t a, input pixel_t b);
        int d;
        d = int'(a) - int'(b);
        return (d < 0) ? -d : d;
    endfunction

    // three banks after the writer, idle counts as bank 3 writing.
    task automatic assemble_strip();
        int        first;
        ref_word_u w;
        first = 0;
        if (m_rsel[0]) first = 1;
        else if (m_rsel[1]) first = 2;
        else if (m_rsel[2]) first = 3;
        for (int p = 0; p < `ME_STRIP_PIX; p++) begin
            w = m_q[(first + p / `ME_PIX_PER_WORD) % `ME_BANKS];
            m_strip[p] = w.pix[p % `ME_PIX_PER_WORD];
        end
    endtask

    task automatic select_stage(input logic in_rst);
        int min_sad;
        int min_off;
        int hits;
        if (in_rst) begin
            m_best_valid = 1'b0;
            m_best_sad   = 0;
            m_best_off   = 0;
        end else begin
            m_best_valid = m_vec_valid;
            if (m_vec_valid) begin
                min_sad = m_vec[0];
                min_off = 0;
                hits    = 0;
                for (int k = 1; k < `ME_OFFSETS; k++) begin
                    if (m_vec[k] < min_sad) begin
                        min_sad = m_vec[k];
                        min_off = k;
                    end
                end
                for (int k = 0; k < `ME_OFFSETS; k++) begin
                    if (m_vec[k] == min_sad) hits++;
                end
                m_best_sad = min_sad;
                m_best_off = min_off;
                mdl_res++;
                if (hits > 1) tie_res++;
                if (min_sad == MAX_SAD) ext_res++;
            end
        end
    endtask

    task automatic accum_stage(input logic in_rst, input logic in_nl, input ref_word_u in_cur);
        int col;
        if (in_rst || in_nl) begin
            m_cnt       = 0;
            m_vec_valid = 1'b0;
            for (int k = 0; k < `ME_OFFSETS; k++) m_acc[k] = 0;
        end else begin
            m_vec_valid = m_ready && (m_cnt == `ME_BLOCK_COLS - 1);
            if (m_ready) begin
                for (int k = 0; k < `ME_OFFSETS; k++) begin
                    col = 0;
                    for (int i = 0; i < COL_PIX; i++) begin
                        col += pix_dist(in_cur.pix[i], m_strip[k + i]);
                    end
                    if (m_vec_valid) m_vec[k] = m_acc[k] + col; // 8th column included.
                    m_acc[k] = m_vec_valid ? 0 : m_acc[k] + col;
                end
                m_cnt = (m_cnt == `ME_BLOCK_COLS - 1) ? 0 : m_cnt + 1;
            end
        end
    endtask

    task automatic buffer_stage(input logic in_rst, input logic in_nl, input ref_word_u in_ref);
        for (int b = 0; b < `ME_BANKS; b++) begin
            m_q[b].word = m_mem[b][m_addr]; // read before write.
            if (m_wsel[b]) m_mem[b][m_addr] = in_ref.word;
        end
        if (in_rst || in_nl) begin
            m_ready = 1'b0;
            m_addr  = 0;
            m_wsel  = '0;
            m_rsel  = '0;
        end else begin
            if (m_wsel[`ME_BANKS-1] && !m_ready) ready_rises++;
            if (m_wsel[`ME_BANKS-1]) m_ready = 1'b1;
            m_rsel = m_wsel;
            if (m_addr == LAST_ADDR) begin
                m_addr = 0;
                m_wsel = (m_wsel == '0 || m_wsel[`ME_BANKS-1]) ? FIRST_BANK : m_wsel << 1;
            end else begin
                m_addr++;
            end
        end
        assemble_strip();
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // model update and stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge clk) begin : drive_and_model
        ref_word_u nxt_ref;
        ref_word_u nxt_cur;
        logic      nxt_nl;
        int        off;
        select_stage(rst);
        accum_stage(rst, next_line, cur_col);
        buffer_stage(rst, next_line, ref_in);
        nxt_nl       = 1'b0;
        nxt_ref.word = '0;
        nxt_cur.word = '0;
        if (!rst) begin
            cyc++;
            if (cyc <= RAND_CYCLES) begin
                nxt_ref.word = {$random(seed), $random(seed)};
                nxt_cur.word = {$random(seed), $random(seed)};
                if (m_addr == LAST_ADDR) begin
                    nxt_nl = (($random(seed) & 15) == 0); // at a line boundary.
                end else begin
                    nxt_nl = (($unsigned($random(seed)) % 500) == 0);
                end
            end else if (cyc <= RAND_CYCLES + TIE_CYCLES) begin
                if (cyc == RAND_CYCLES + 1) begin
                    tie_word = {$random(seed), $random(seed)};
                    tie_a    = $unsigned($random(seed)) % `ME_OFFSETS;
                    tie_b    = $unsigned($random(seed)) % `ME_OFFSETS;
                end
                nxt_ref.word = tie_word;
                off = (m_cnt % 2 == 1) ? tie_b : tie_a; // alternate the copied offset.
                for (int i = 0; i < COL_PIX; i++) nxt_cur.pix[i] = m_strip[off + i];
            end else begin
                nxt_ref.word = '0;
                nxt_cur.word = '1;
            end
        end
        next_line <= nxt_nl;
        ref_in    <= nxt_ref;
        cur_col   <= nxt_cur;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(negedge clk) begin
        if (!rst) begin
            chk_cnt += 2;
            assert (sram_ready == m_ready) else begin
                err_cnt++;
                $display("ERR %0t: sram_ready %0b, expected %0b", $time, sram_ready, m_ready);
            end
            assert (best_valid == m_best_valid) else begin
                err_cnt++;
                $display("ERR %0t: best_valid %0b, expected %0b", $time, best_valid, m_best_valid);
            end
            if (best_valid) dut_res++;
            if (best_valid && m_best_valid) begin
                chk_cnt += 2;
                assert (int'(best.sad) == m_best_sad) else begin
                    err_cnt++;
                    $display("ERR %0t: best.sad %0d, expected %0d", $time, best.sad, m_best_sad);
                end
                assert (int'(best.offset) == m_best_off) else begin
                    err_cnt++;
                    $display("ERR %0t: best.offset %0d, expected %0d",
                             $time, best.offset, m_best_off);
                end
            end
        end
    end

    initial begin
        int fin_err;
        fin_err = 0;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        repeat (RUN_CYCLES) @(negedge clk);
        #(CLK_PERIOD / 8);
        assert (dut_res == mdl_res) else begin
            fin_err++;
            $display("ERR %0t: %0d results seen, expected %0d", $time, dut_res, mdl_res);
        end
        assert (tie_res > 0) else begin
            fin_err++;
            $display("no result with a tied minimum was produced");
        end
        assert (ext_res > 0) else begin
            fin_err++;
            $display("the extreme pixel phase never gave a full-scale SAD");
        end
        assert (ready_rises > 1) else begin
            fin_err++;
            $display("sram_ready never rose again after a next_line");
        end
        $display("checks %0d, errors %0d, results %0d, ties %0d, extremes %0d",
                 chk_cnt, err_cnt + fin_err, dut_res, tie_res, ext_res);
        if (err_cnt + fin_err == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #((RST_CYCLES + RUN_CYCLES + 200) * CLK_PERIOD);
        $display("timeout: the run did not end within %0d cycles", RST_CYCLES + RUN_CYCLES + 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: design/me_config.svh
`ifndef ME_CONFIG_SVH
`define ME_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// line buffer geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ME_LINE_WORDS    23 // words per line, also bank depth.
`define ME_BANKS         4  // rotating banks.
`define ME_PIX_PER_WORD  8  // pixels in one 64-bit word.

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// search geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define ME_STRIP_PIX     23 // pixels in a reference strip.
`define ME_BLOCK_COLS    8  // columns per result.
`define ME_OFFSETS       16 // strip pixels minus column height plus one.
`define ME_SAD_W         14 // holds 8x8x255.

`endif

// File: design/me_pkg.sv
`include "me_config.svh"

package me_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pixel data
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [7:0] pixel_t; // unsigned luma.

    // element 0 sits in the top byte of the word
    typedef union packed {
        logic [`ME_PIX_PER_WORD*8-1:0] word;
        pixel_t [0:`ME_PIX_PER_WORD-1] pix;
    } ref_word_u;

    typedef struct packed {
        pixel_t [0:`ME_STRIP_PIX-1] pix; // pixel 0 is the top.
        logic                       valid;
    } ref_strip_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        logic [`ME_OFFSETS-1:0][`ME_SAD_W-1:0] sad; // indexed by offset.
        logic                                  valid;
    } sad_vec_t;

    typedef struct packed {
        logic [$clog2(`ME_OFFSETS)-1:0] offset;
        logic [`ME_SAD_W-1:0]           sad;
    } best_match_t;

endpackage

// File: design/me_search_top.sv
module me_search_top
    import me_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        next_line,
    input  ref_word_u   ref_in,
    input  ref_word_u   cur_col,
    output logic        sram_ready,
    output best_match_t best,
    output logic        best_valid
);

    ref_strip_t strip; // reference column window.
    sad_vec_t   sads;  // per-offset block totals.

    ref_line_buffer u_refbuf (
        .clk        (clk),
        .rst        (rst),
        .next_line  (next_line),
        .ref_in     (ref_in),
        .strip      (strip),
        .sram_ready (sram_ready)
    );

    sad_accum u_sad (
        .clk        (clk),
        .rst        (rst),
        .next_line  (next_line),
        .strip      (strip),
        .cur_col    (cur_col),
        .sads       (sads)
    );

    min_select u_min (
        .clk        (clk),
        .rst        (rst),
        .sads       (sads),
        .best       (best),
        .best_valid (best_valid)
    );

endmodule

// File: design/min_select.sv
`include "me_config.svh"

module min_select
    import me_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  sad_vec_t    sads,
    output best_match_t best,
    output logic        best_valid
);

    localparam int OFF_W  = $clog2(`ME_OFFSETS);
    localparam int LEVELS = $clog2(`ME_OFFSETS);

    best_match_t node [`ME_OFFSETS];
    best_match_t winner;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // comparison tree
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // each pair keeps its lower half unless the upper half is strictly
    // smaller, so ties resolve to the lowest offset.
    always_comb begin
        int step;
        for (int k = 0; k < `ME_OFFSETS; k++) begin
            node[k].offset = OFF_W'(k);
            node[k].sad    = sads.sad[k];
        end
        for (int lvl = 0; lvl < LEVELS; lvl++) begin
            step = 1 << lvl;
            for (int j = 0; j < `ME_OFFSETS; j += 2 << lvl) begin
                if (node[j + step].sad < node[j].sad) begin
                    node[j] = node[j + step];
                end
            end
        end
        winner = node[0];
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            best       <= '0;
            best_valid <= 1'b0;
        end else begin
            best_valid <= sads.valid; // one edge after the vector.
            if (sads.valid) begin
                best <= winner; // held until the next group.
            end
        end
    end

endmodule

// File: design/ref_line_buffer.sv
`include "me_config.svh"

module ref_line_buffer
    import me_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       next_line,
    input  ref_word_u  ref_in,
    output ref_strip_t strip,
    output logic       sram_ready
);

    localparam logic [4:0] LAST_ADDR = 5'(`ME_LINE_WORDS - 1);
    localparam logic [`ME_BANKS-1:0] FIRST_BANK = `ME_BANKS'(1);
    localparam int TAIL_PIX = `ME_STRIP_PIX - 2 * `ME_PIX_PER_WORD; // from the third bank.

    logic [4:0]           addr;
    logic [`ME_BANKS-1:0] wr_sel; // one-hot writer, zero while idle.
    logic [`ME_BANKS-1:0] rd_sel; // writer at the time of the last read.
    logic [`ME_BANKS-1:0] we;
    ref_word_u            q [`ME_BANKS];

    assign we = wr_sel;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and bank rotation
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            addr   <= '0;
            wr_sel <= '0;
            rd_sel <= '0;
        end else if (next_line) begin
            addr   <= '0;
            wr_sel <= '0;
            rd_sel <= '0;
        end else begin
            rd_sel <= wr_sel; // bank data lags by one edge.
            if (addr == LAST_ADDR) begin
                addr <= '0;
                if (wr_sel == '0 || wr_sel[`ME_BANKS-1]) begin
                    wr_sel <= FIRST_BANK;
                end else begin
                    wr_sel <= wr_sel << 1;
                end
            end else begin
                addr <= addr + 5'd1;
            end
        end
    end

    // three banks hold data once bank 3 takes over.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sram_ready <= 1'b0;
        end else if (next_line) begin
            sram_ready <= 1'b0;
        end else if (wr_sel[`ME_BANKS-1]) begin
            sram_ready <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // strip assembly
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        strip.valid = sram_ready;
        if (rd_sel[0]) begin
            strip.pix = {q[1].pix, q[2].pix, q[3].pix[0:TAIL_PIX-1]};
        end else if (rd_sel[1]) begin
            strip.pix = {q[2].pix, q[3].pix, q[0].pix[0:TAIL_PIX-1]};
        end else if (rd_sel[2]) begin
            strip.pix = {q[3].pix, q[0].pix, q[1].pix[0:TAIL_PIX-1]};
        end else begin
            strip.pix = {q[0].pix, q[1].pix, q[2].pix[0:TAIL_PIX-1]}; // bank 3 or idle.
        end
    end

    sram_bank u_bank0 (
        .clk  (clk),
        .addr (addr),
        .we   (we[0]),
        .d    (ref_in),
        .q    (q[0])
    );

    sram_bank u_bank1 (
        .clk  (clk),
        .addr (addr),
        .we   (we[1]),
        .d    (ref_in),
        .q    (q[1])
    );

    sram_bank u_bank2 (
        .clk  (clk),
        .addr (addr),
        .we   (we[2]),
        .d    (ref_in),
        .q    (q[2])
    );

    sram_bank u_bank3 (
        .clk  (clk),
        .addr (addr),
        .we   (we[3]),
        .d    (ref_in),
        .q    (q[3])
    );

endmodule

// File: design/sad_accum.sv
`include "me_config.svh"

module sad_accum
    import me_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       next_line,
    input  ref_strip_t strip,
    input  ref_word_u  cur_col,
    output sad_vec_t   sads
);

    localparam int CNT_W = $clog2(`ME_BLOCK_COLS);
    localparam int WIN   = `ME_STRIP_PIX - `ME_OFFSETS + 1; // column height.
    localparam int COL_W = $clog2(`ME_PIX_PER_WORD * 255 + 1);
    localparam logic [CNT_W-1:0] LAST_COL = CNT_W'(`ME_BLOCK_COLS - 1);

    logic [CNT_W-1:0]                      col_cnt;
    logic                                  last_col;
    logic                                  col_done;
    logic [`ME_OFFSETS-1:0][COL_W-1:0]     col_sad;
    logic [`ME_OFFSETS-1:0][`ME_SAD_W-1:0] acc;
    logic [`ME_OFFSETS-1:0][`ME_SAD_W-1:0] sad_q;
    logic                                  valid_q;

    function automatic pixel_t abs_diff(input pixel_t a, input pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    assign last_col = (col_cnt == LAST_COL);
    assign col_done = strip.valid && last_col;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one column, all offsets in parallel
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        for (int k = 0; k < `ME_OFFSETS; k++) begin
            col_sad[k] = '0;
            for (int i = 0; i < WIN; i++) begin
                col_sad[k] = col_sad[k] + COL_W'(abs_diff(cur_col.pix[i], strip.pix[k + i]));
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // accumulation over the block
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            col_cnt <= '0;
            acc     <= '0;
            valid_q <= 1'b0;
        end else if (next_line) begin
            col_cnt <= '0;
            acc     <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= col_done; // single-cycle pulse.
            if (strip.valid) begin
                col_cnt <= last_col ? '0 : col_cnt + CNT_W'(1);
                for (int k = 0; k < `ME_OFFSETS; k++) begin
                    acc[k] <= last_col ? '0 : acc[k] + `ME_SAD_W'(col_sad[k]);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (col_done) begin
            for (int k = 0; k < `ME_OFFSETS; k++) begin
                sad_q[k] <= acc[k] + `ME_SAD_W'(col_sad[k]); // includes the 8th column.
            end
        end
    end

    assign sads.sad   = sad_q;
    assign sads.valid = valid_q;

endmodule

// File: design/sram_bank.sv
`include "me_config.svh"

module sram_bank
    import me_pkg::*;
(
    input  logic       clk,
    input  logic [4:0] addr,
    input  logic       we,
    input  ref_word_u  d,
    output ref_word_u  q
);

    logic [63:0] mem [0:`ME_LINE_WORDS-1]; // one picture line.

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= d.word;
        end
        q.word <= mem[addr]; // old contents on a write cycle.
    end

endmodule

// File: list.f
+incdir+design
design/me_pkg.sv
design/sram_bank.sv
design/ref_line_buffer.sv
design/sad_accum.sv
design/min_select.sv
design/me_search_top.sv
bench/me_search_checker.sv
bench/me_search_tb.sv

// File: run.sh
#!/bin/sh
# builds the motion search testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module me_search_tb \
    --Mdir obj_dir \
    -o me_search_sim \
    -f list.f

./obj_dir/me_search_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi

echo "simulation finished without failure"
